// ==== src/axi_lite_pkg.sv ====
// AXI-Lite constants shared by the access unit and the SRAM slave.
// Single-beat transfers only, so there are no burst length or last fields.
// Only OKAY and SLVERR are ever returned.
package axi_lite_pkg;

	// bus widths
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// transfer size, log2 of the byte count
	localparam logic [2:0] size_byte = 3'b000;
	localparam logic [2:0] size_half = 3'b001;
	localparam logic [2:0] size_word = 3'b010;

endpackage

// ==== src/mem_op_pkg.sv ====
// Memory operation encodings and the two stage payloads.
// The op coding matches the execute stage: 00 none, 01 load, 10 store.
// Stores reuse the load width codes: lb for sb, lh for sh, lw for sw.
package mem_op_pkg;

	typedef enum logic [1:0] {
		op_none  = 2'b00,
		op_load  = 2'b01,
		op_store = 2'b10
	} mem_op_t;

	typedef enum logic [2:0] {
		w_lb  = 3'd0,
		w_lbu = 3'd1,
		w_lh  = 3'd2,
		w_lhu = 3'd3,
		w_lw  = 3'd4
	} mem_width_t;

	// exception numbers for a bus error
	localparam logic [7:0] exc_load_fault  = 8'd5;
	localparam logic [7:0] exc_store_fault = 8'd7;

	// execute to memory, 116 bits
	typedef struct packed {
		mem_op_t    op;
		mem_width_t width;
		logic [31:0] addr;
		logic [31:0] store_data;
		logic [31:0] result;
		logic [4:0]  rd;
		logic        rd_we;
		logic        irq;
		logic [7:0]  irq_no;
	} ex_mem_t;

	// memory to write-back, 47 bits
	typedef struct packed {
		logic [4:0]  rd;
		logic        rd_we;
		logic [31:0] data;
		logic        irq;
		logic [7:0]  irq_no;
	} mem_wb_t;

endpackage

// ==== src/pipe_slice.sv ====
// One-entry registered pipeline slice with a valid/ready handshake.
// Output is presented one cycle after acceptance.
// in_ready depends combinationally on out_ready when the slice is full.
module pipe_slice #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_item,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_item
);

	logic     full;
	payload_t data_q;

	// accept when empty or when the held item leaves this cycle
	assign in_ready  = !full || out_ready;
	assign out_valid = full;
	assign out_item  = data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (in_valid && in_ready) begin
			full <= 1'b1;
		end else if (out_ready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_item;
		end
	end

	// a stalled item must not change under the consumer
	a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_item));

endmodule

// ==== src/lane_align.sv ====
// Byte lane placement for stores and lane extraction for loads.
// Purely combinational. Misaligned accesses get an all-zero strobe,
// and their load data is not meaningful.
module lane_align import mem_op_pkg::*; (
	input  mem_width_t  width,
	input  logic [1:0]  addr_lo,
	input  logic [31:0] store_data,
	output logic [3:0]  wstrb,
	output logic [31:0] wdata,
	input  logic [31:0] rdata,
	output logic [31:0] load_data
);

	logic [4:0]  shamt;
	logic [31:0] lane;

	// byte offset in bits
	assign shamt = {addr_lo, 3'b000};

	// store data moves up to its lane, load data moves down to bit 0
	assign wdata = store_data << shamt;
	assign lane  = rdata >> shamt;

	always_comb begin
		case (width)
			w_lb: begin
				wstrb = 4'b0001 << addr_lo;
			end
			w_lh: begin
				case (addr_lo)
					2'b00:   wstrb = 4'b0011;
					2'b10:   wstrb = 4'b1100;
					default: wstrb = 4'b0000;
				endcase
			end
			w_lw: begin
				wstrb = (addr_lo == 2'b00) ? 4'b1111 : 4'b0000;
			end
			default: begin
				wstrb = 4'b0000;
			end
		endcase
	end

	always_comb begin
		case (width)
			w_lb:    load_data = {{24{lane[7]}}, lane[7:0]};
			w_lbu:   load_data = {24'b0, lane[7:0]};
			w_lh:    load_data = {{16{lane[15]}}, lane[15:0]};
			w_lhu:   load_data = {16'b0, lane[15:0]};
			default: load_data = lane;
		endcase
	end

endmodule

// ==== src/mem_access_unit.sv ====
// Memory stage controller and AXI-Lite master.
// Holds one item at a time and accepts only when idle.
// aw and w are raised together. Single-beat transfers only.
// A bus error turns the item into exception 5 (load) or 7 (store)
// and drops its register write.
module mem_access_unit import axi_lite_pkg::*, mem_op_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	output logic              in_ready,
	input  ex_mem_t           in_item,
	output logic              out_valid,
	input  logic              out_ready,
	output mem_wb_t           out_item,
	output logic [addr_w-1:0] araddr,
	output logic              arvalid,
	input  logic              arready,
	output logic [2:0]        arsize,
	input  logic [data_w-1:0] rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready,
	output logic [addr_w-1:0] awaddr,
	output logic              awvalid,
	input  logic              awready,
	output logic [2:0]        awsize,
	output logic [data_w-1:0] wdata,
	output logic [3:0]        wstrb,
	output logic              wvalid,
	input  logic              wready,
	input  logic [1:0]        bresp,
	input  logic              bvalid,
	output logic              bready,
	output mem_width_t        al_width,
	output logic [1:0]        al_addr_lo,
	output logic [31:0]       al_store_data,
	input  logic [3:0]        al_wstrb,
	input  logic [31:0]       al_wdata,
	input  logic [31:0]       al_load_data
);

	typedef enum logic [2:0] {
		s_idle,
		s_issue,
		s_raddr,
		s_rdata,
		s_write,
		s_wresp,
		s_send
	} state_t;

	state_t  state;
	ex_mem_t item_q;
	mem_wb_t res_q;

	function automatic logic [2:0] size_of(mem_width_t w);
		case (w)
			w_lb, w_lbu: return size_byte;
			w_lh, w_lhu: return size_half;
			default:     return size_word;
		endcase
	endfunction

	assign in_ready  = (state == s_idle);
	assign out_valid = (state == s_send);
	assign out_item  = res_q;

	// aligner always sees the latched item
	assign al_width      = item_q.width;
	assign al_addr_lo    = item_q.addr[1:0];
	assign al_store_data = item_q.store_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= s_idle;
			arvalid <= 1'b0;
			rready  <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			bready  <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (in_valid) begin
						item_q       <= in_item;
						// default result is a plain pass-through
						res_q.rd     <= in_item.rd;
						res_q.rd_we  <= in_item.rd_we;
						res_q.data   <= in_item.result;
						res_q.irq    <= in_item.irq;
						res_q.irq_no <= in_item.irq_no;
						if (in_item.op == op_load || in_item.op == op_store) begin
							state <= s_issue;
						end else begin
							state <= s_send;
						end
					end
				end
				s_issue: begin
					if (item_q.op == op_load) begin
						araddr  <= item_q.addr;
						arsize  <= size_of(item_q.width);
						arvalid <= 1'b1;
						state   <= s_raddr;
					end else begin
						awaddr  <= item_q.addr;
						awsize  <= size_of(item_q.width);
						wdata   <= al_wdata;
						wstrb   <= al_wstrb;
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						state   <= s_write;
					end
				end
				s_raddr: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= s_rdata;
					end
				end
				s_rdata: begin
					if (rvalid) begin
						rready <= 1'b0;
						if (rresp == resp_okay) begin
							res_q.data <= al_load_data;
						end else begin
							res_q.irq    <= 1'b1;
							res_q.irq_no <= exc_load_fault;
							res_q.rd_we  <= 1'b0;
						end
						state <= s_send;
					end
				end
				s_write: begin
					// aw and w may complete in different cycles
					if (awready) begin
						awvalid <= 1'b0;
					end
					if (wready) begin
						wvalid <= 1'b0;
					end
					if ((!awvalid || awready) && (!wvalid || wready)) begin
						bready <= 1'b1;
						state  <= s_wresp;
					end
				end
				s_wresp: begin
					if (bvalid) begin
						bready <= 1'b0;
						if (bresp != resp_okay) begin
							res_q.irq    <= 1'b1;
							res_q.irq_no <= exc_store_fault;
							res_q.rd_we  <= 1'b0;
						end
						state <= s_send;
					end
				end
				s_send: begin
					if (out_ready) begin
						state <= s_idle;
					end
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	// only one transaction is in flight
	a_one_dir: assert property (@(posedge clk) disable iff (reset)
		!(arvalid && awvalid));

	a_ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid);

endmodule

// ==== src/axi_sram.sv ====
// AXI-Lite slave backed by a word array of mem_words entries.
// aw and w are taken in the same cycle, so the master must raise them together.
// rvalid or bvalid follows the address handshake after rsp_delay cycles,
// rsp_delay must be at least 1.
// Addresses at or beyond mem_words*4 answer SLVERR, write nothing and read zero.
// The array has no reset and starts with unknown contents.
module axi_sram import axi_lite_pkg::*; #(
	parameter int mem_words = 256,
	parameter int rsp_delay = 2
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [addr_w-1:0] araddr,
	input  logic              arvalid,
	output logic              arready,
	input  logic [2:0]        arsize,
	output logic [data_w-1:0] rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready,
	input  logic [addr_w-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  logic [2:0]        awsize,
	input  logic [data_w-1:0] wdata,
	input  logic [3:0]        wstrb,
	input  logic              wvalid,
	output logic              wready,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready
);

	localparam int idx_w = $clog2(mem_words);
	localparam int cnt_w = (rsp_delay > 1) ? $clog2(rsp_delay) : 1;

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_resp
	} state_t;

	logic [data_w-1:0] mem [mem_words];
	state_t            state;
	logic              armed;
	logic [cnt_w-1:0]  cnt;
	logic              is_read;
	logic              ok_q;
	logic [idx_w-1:0]  idx_q;
	logic              ar_ok;
	logic              aw_ok;
	logic              ar_go;
	logic              aw_go;
	logic              aw_open;

	// range check on the word address
	assign ar_ok = araddr[addr_w-1:2] < (addr_w - 2)'(mem_words);
	assign aw_ok = awaddr[addr_w-1:2] < (addr_w - 2)'(mem_words);

	// ready only once out of reset
	assign arready = armed && (state == st_idle);
	assign awready = arready;
	assign wready  = arready;

	// reads win if both show up
	assign ar_go = arvalid && arready;
	assign aw_go = !ar_go && awvalid && wvalid && awready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= st_idle;
			armed  <= 1'b0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			armed <= 1'b1;
			case (state)
				st_idle: begin
					if (ar_go || aw_go) begin
						is_read <= ar_go;
						ok_q    <= ar_go ? ar_ok : aw_ok;
						idx_q   <= araddr[idx_w+1:2];
						cnt     <= cnt_w'(rsp_delay - 1);
						state   <= st_wait;
					end
				end
				st_wait: begin
					if (cnt == '0) begin
						if (is_read) begin
							rvalid <= 1'b1;
							rdata  <= ok_q ? mem[idx_q] : '0;
							rresp  <= ok_q ? resp_okay : resp_slverr;
						end else begin
							bvalid <= 1'b1;
							bresp  <= ok_q ? resp_okay : resp_slverr;
						end
						state <= st_resp;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				st_resp: begin
					if ((rvalid && rready) || (bvalid && bready)) begin
						rvalid <= 1'b0;
						bvalid <= 1'b0;
						state  <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// byte writes at the handshake
	always_ff @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (aw_go && aw_ok && wstrb[b]) begin
				mem[awaddr[idx_w+1:2]][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

	// open write transactions, tracked apart from the FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			aw_open <= 1'b0;
		end else if (awvalid && awready) begin
			aw_open <= 1'b1;
		end else if (bvalid && bready) begin
			aw_open <= 1'b0;
		end
	end

	a_b_after_aw: assert property (@(posedge clk) disable iff (reset)
		$rose(bvalid) |-> aw_open);

	// nothing wider than the data bus
	a_size_fits: assert property (@(posedge clk) disable iff (reset)
		(arvalid |-> arsize <= size_word) and (awvalid |-> awsize <= size_word));

endmodule

// ==== src/mem_stage_top.sv ====
// Memory access stage: input slice, access unit, output slice and on-chip SRAM.
// Latency varies with the bus delay, and wb_valid marks the result.
// Items leave in the order they enter.
module mem_stage_top import axi_lite_pkg::*, mem_op_pkg::*; #(
	parameter int mem_words = 256,
	parameter int rsp_delay = 2
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       ex_valid,
	output logic       ex_ready,
	input  mem_op_t    ex_op,
	input  mem_width_t ex_width,
	input  logic [31:0] ex_addr,
	input  logic [31:0] ex_store_data,
	input  logic [31:0] ex_result,
	input  logic [4:0]  ex_rd,
	input  logic        ex_rd_we,
	input  logic        ex_irq,
	input  logic [7:0]  ex_irq_no,
	output logic        wb_valid,
	input  logic        wb_ready,
	output logic [4:0]  wb_rd,
	output logic        wb_rd_we,
	output logic [31:0] wb_data,
	output logic        wb_irq,
	output logic [7:0]  wb_irq_no
);

	ex_mem_t ex_item;
	ex_mem_t in_item;
	mem_wb_t out_item;
	mem_wb_t wb_item;
	logic    in_valid;
	logic    in_ready;
	logic    out_valid;
	logic    out_ready;

	logic [addr_w-1:0] araddr;
	logic [addr_w-1:0] awaddr;
	logic [data_w-1:0] rdata;
	logic [data_w-1:0] wdata;
	logic [2:0]        arsize;
	logic [2:0]        awsize;
	logic [1:0]        rresp;
	logic [1:0]        bresp;
	logic [3:0]        wstrb;
	logic              arvalid;
	logic              arready;
	logic              rvalid;
	logic              rready;
	logic              awvalid;
	logic              awready;
	logic              wvalid;
	logic              wready;
	logic              bvalid;
	logic              bready;

	mem_width_t  al_width;
	logic [1:0]  al_addr_lo;
	logic [31:0] al_store_data;
	logic [3:0]  al_wstrb;
	logic [31:0] al_wdata;
	logic [31:0] al_load_data;

	// pack the execute fields, unpack the write-back fields
	assign ex_item = '{op: ex_op, width: ex_width, addr: ex_addr,
		store_data: ex_store_data, result: ex_result, rd: ex_rd,
		rd_we: ex_rd_we, irq: ex_irq, irq_no: ex_irq_no};

	assign wb_rd     = wb_item.rd;
	assign wb_rd_we  = wb_item.rd_we;
	assign wb_data   = wb_item.data;
	assign wb_irq    = wb_item.irq;
	assign wb_irq_no = wb_item.irq_no;

	pipe_slice #(.payload_t(ex_mem_t)) u_in_slice (
		.clk(clk), .reset(reset),
		.in_valid(ex_valid), .in_ready(ex_ready), .in_item(ex_item),
		.out_valid(in_valid), .out_ready(in_ready), .out_item(in_item)
	);

	mem_access_unit u_access (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_item(in_item),
		.out_valid(out_valid), .out_ready(out_ready), .out_item(out_item),
		.araddr(araddr), .arvalid(arvalid), .arready(arready), .arsize(arsize),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .awsize(awsize),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.al_width(al_width), .al_addr_lo(al_addr_lo), .al_store_data(al_store_data),
		.al_wstrb(al_wstrb), .al_wdata(al_wdata), .al_load_data(al_load_data)
	);

	lane_align u_align (
		.width(al_width), .addr_lo(al_addr_lo), .store_data(al_store_data),
		.wstrb(al_wstrb), .wdata(al_wdata),
		.rdata(rdata), .load_data(al_load_data)
	);

	pipe_slice #(.payload_t(mem_wb_t)) u_out_slice (
		.clk(clk), .reset(reset),
		.in_valid(out_valid), .in_ready(out_ready), .in_item(out_item),
		.out_valid(wb_valid), .out_ready(wb_ready), .out_item(wb_item)
	);

	axi_sram #(.mem_words(mem_words), .rsp_delay(rsp_delay)) u_sram (
		.clk(clk), .reset(reset),
		.araddr(araddr), .arvalid(arvalid), .arready(arready), .arsize(arsize),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .awsize(awsize),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

endmodule

// ==== tests/tb_tasks.svh ====
// Testbench helpers: item driver, drain wait and the random generator.
// Included inside tb_mem_stage. Every task is entered at a falling edge
// and returns at a falling edge. Once a timeout is seen, every task
// returns at once.
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

localparam logic [31:0] lcg_seed = 32'd85655;

logic [31:0] rnd_state = lcg_seed;

// one step of a 32-bit linear congruential generator
function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// upper bits only, the low bits of an LCG repeat quickly
function automatic logic [15:0] rand16();
	rnd_state = lcg_step(rnd_state);
	return rnd_state[31:16];
endfunction

function automatic logic [31:0] rand32();
	logic [15:0] hi;
	logic [15:0] lo;
	hi = rand16();
	lo = rand16();
	return {hi, lo};
endfunction

task automatic send_item(input mem_op_t op, input mem_width_t width,
	input logic [31:0] addr, input logic [31:0] sdata, input logic [31:0] result,
	input logic [4:0] rd, input logic rd_we, input logic irq, input logic [7:0] irq_no);
	int waited;
	waited = 0;
	if (timed_out) return;
	expect_item(op, width, addr, sdata, result, rd, rd_we, irq, irq_no);
	ex_valid      = 1'b1;
	ex_op         = op;
	ex_width      = width;
	ex_addr       = addr;
	ex_store_data = sdata;
	ex_result     = result;
	ex_rd         = rd;
	ex_rd_we      = rd_we;
	ex_irq        = irq;
	ex_irq_no     = irq_no;
	// ex_ready comes from registers, so it is stable here
	while (!ex_ready && waited < wait_limit) begin
		@(negedge clk);
		waited++;
	end
	if (!ex_ready) begin
		report_timeout("ex_ready");
	end else begin
		@(negedge clk);
		sent_count++;
	end
	ex_valid = 1'b0;
endtask

// memory item with a register write and no incoming exception
task automatic send_mem(input mem_op_t op, input mem_width_t width,
	input logic [31:0] addr, input logic [31:0] sdata, input logic [4:0] rd);
	send_item(op, width, addr, sdata, rand32(), rd, 1'b1, 1'b0, 8'h00);
endtask

// wait until every expected result has been handed to write-back
task automatic wait_all_received();
	int waited;
	waited = 0;
	if (timed_out) return;
	while (exp_q.size() != 0 && waited < drain_limit) begin
		@(negedge clk);
		waited++;
	end
	if (exp_q.size() != 0) begin
		report_timeout("write-back result");
	end
	// lets the checks of the last handshake run
	@(negedge clk);
endtask

`endif

// ==== tests/tb_mem_stage.sv ====
// Testbench for the memory access stage.
// Each write-back handshake is checked by concurrent assertions against a
// queue of expected results built from a byte-wide reference memory.
// Only aligned accesses are issued, and loads read bytes written earlier,
// since the SRAM array starts unknown.
module tb_mem_stage import mem_op_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int mem_words   = 256;
	localparam int mem_bytes   = mem_words * 4;
	localparam int wait_limit  = 200;
	localparam int drain_limit = 4000;

	logic        clk = 1'b0;
	logic        reset;
	logic        ex_valid;
	logic        ex_ready;
	mem_op_t     ex_op;
	mem_width_t  ex_width;
	logic [31:0] ex_addr;
	logic [31:0] ex_store_data;
	logic [31:0] ex_result;
	logic [4:0]  ex_rd;
	logic        ex_rd_we;
	logic        ex_irq;
	logic [7:0]  ex_irq_no;
	logic        wb_valid;
	logic        wb_ready;
	logic [4:0]  wb_rd;
	logic        wb_rd_we;
	logic [31:0] wb_data;
	logic        wb_irq;
	logic [7:0]  wb_irq_no;

	logic [7:0]  ref_mem [mem_bytes];
	mem_wb_t     exp_q [$];
	mem_wb_t     got_q;
	mem_wb_t     head_q;
	logic        hs_q;
	logic        orphan_q;
	logic        timed_out = 1'b0;
	logic        bp_on = 1'b0;
	logic [31:0] bp_state;
	int          error_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          sent_count = 0;
	int          received_count = 0;

	`include "tb_tasks.svh"

	mem_stage_top #(.mem_words(mem_words), .rsp_delay(2)) DUT (.*);

	always #20 clk = ~clk;

	// snapshot each handshake for the checks half a cycle later
	always @(posedge clk) begin
		if (reset) begin
			hs_q     <= 1'b0;
			orphan_q <= 1'b0;
		end else begin
			hs_q     <= wb_valid && wb_ready;
			orphan_q <= wb_valid && wb_ready && exp_q.size() == 0;
			if (wb_valid && wb_ready) begin
				got_q <= '{rd: wb_rd, rd_we: wb_rd_we, data: wb_data,
					irq: wb_irq, irq_no: wb_irq_no};
				received_count++;
				if (exp_q.size() != 0) begin
					head_q <= exp_q.pop_front();
				end
			end
		end
	end

	// write-back back-pressure with about three cycles in four ready
	always @(negedge clk) begin
		if (bp_on) begin
			bp_state = lcg_step(bp_state);
			wb_ready <= bp_state[31] | bp_state[30];
		end else begin
			wb_ready <= 1'b1;
		end
	end

	a_rd: assert property (@(negedge clk) disable iff (reset)
		hs_q && !orphan_q |-> got_q.rd == head_q.rd)
		else begin
			$display("[ERROR] wb_rd got %h expected %h", got_q.rd, head_q.rd);
			error_count++;
		end
	a_rd_we: assert property (@(negedge clk) disable iff (reset)
		hs_q && !orphan_q |-> got_q.rd_we == head_q.rd_we)
		else begin
			$display("[ERROR] wb_rd_we got %h expected %h", got_q.rd_we, head_q.rd_we);
			error_count++;
		end
	a_data: assert property (@(negedge clk) disable iff (reset)
		hs_q && !orphan_q |-> got_q.data == head_q.data)
		else begin
			$display("[ERROR] wb_data got %h expected %h", got_q.data, head_q.data);
			error_count++;
		end
	a_irq: assert property (@(negedge clk) disable iff (reset)
		hs_q && !orphan_q |-> got_q.irq == head_q.irq)
		else begin
			$display("[ERROR] wb_irq got %h expected %h", got_q.irq, head_q.irq);
			error_count++;
		end
	a_irq_no: assert property (@(negedge clk) disable iff (reset)
		hs_q && !orphan_q |-> got_q.irq_no == head_q.irq_no)
		else begin
			$display("[ERROR] wb_irq_no got %h expected %h", got_q.irq_no, head_q.irq_no);
			error_count++;
		end
	a_orphan: assert property (@(negedge clk) disable iff (reset) !orphan_q)
		else begin
			$display("write-back handed over a result that no item was expected to give");
			error_count++;
		end

	// reference model updates ref_mem in issue order and queues the result
	function automatic void expect_item(input mem_op_t op, input mem_width_t width,
		input logic [31:0] addr, input logic [31:0] sdata, input logic [31:0] result,
		input logic [4:0] rd, input logic rd_we, input logic irq, input logic [7:0] irq_no);
		mem_wb_t     e;
		int          nbytes;
		logic [31:0] raw;
		logic        in_range;
		e        = '{rd: rd, rd_we: rd_we, data: result, irq: irq, irq_no: irq_no};
		nbytes   = (width == w_lw) ? 4 : (width == w_lh || width == w_lhu) ? 2 : 1;
		in_range = addr < 32'(mem_bytes);
		raw      = '0;
		if (op != op_none && !in_range) begin
			e.irq    = 1'b1;
			e.irq_no = (op == op_load) ? 8'd5 : 8'd7;
			e.rd_we  = 1'b0;
		end else if (op == op_store) begin
			for (int i = 0; i < nbytes; i++) begin
				ref_mem[addr[9:0] + 10'(i)] = sdata[8*i +: 8];
			end
		end else if (op == op_load) begin
			for (int i = 0; i < nbytes; i++) begin
				raw[8*i +: 8] = ref_mem[addr[9:0] + 10'(i)];
			end
			case (width)
				w_lb:    e.data = {{24{raw[7]}}, raw[7:0]};
				w_lh:    e.data = {{16{raw[15]}}, raw[15:0]};
				default: e.data = raw;
			endcase
		end
		exp_q.push_back(e);
	endfunction

	task automatic report_timeout(input string what);
		$display("timeout: no %s within the wait limit", what);
		timed_out = 1'b1;
	endtask

	task automatic end_test(input int num, input string name, input int errs_before);
		tests_run++;
		if (timed_out) begin
			tests_failed++;
			$display("test %0d %s: timed out", num, name);
		end else if (error_count != errs_before) begin
			tests_failed++;
			$display("test %0d %s: %0d errors", num, name, error_count - errs_before);
		end else begin
			$display("test %0d %s: ok", num, name);
		end
	endtask

	initial begin
		int          errs;
		int          off;
		int          kind;
		logic [15:0] r;
		logic [31:0] addr;
		mem_width_t  w;
		mem_op_t     op;
		reset         = 1'b1;
		ex_valid      = 1'b0;
		ex_op         = op_none;
		ex_width      = w_lb;
		ex_addr       = '0;
		ex_store_data = '0;
		ex_result     = '0;
		ex_rd         = '0;
		ex_rd_we      = 1'b0;
		ex_irq        = 1'b0;
		ex_irq_no     = '0;
		wb_ready      = 1'b0;
		bp_state      = ~lcg_seed;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		errs = error_count;
		assert (wb_valid == 1'b0)
			else begin
				$display("[ERROR] wb_valid got %h expected 0", wb_valid);
				error_count++;
			end
		assert (ex_ready == 1'b1)
			else begin
				$display("[ERROR] ex_ready got %h expected 1", ex_ready);
				error_count++;
			end
		end_test(1, "reset state", errs);

		errs = error_count;
		for (int k = 0; k < 8; k++) begin
			r = rand16();
			send_item(op_none, w_lw, rand32(), rand32(), rand32(), r[4:0], r[5], r[6], r[15:8]);
		end
		wait_all_received();
		end_test(2, "pass-through items", errs);

		errs = error_count;
		send_mem(op_store, w_lw, 32'h40, 32'hdeadbeef, 5'd3);
		send_mem(op_load, w_lw, 32'h40, 32'h0, 5'd3);
		wait_all_received();
		end_test(3, "word store and load", errs);

		errs = error_count;
		send_mem(op_store, w_lw, 32'h80, 32'h0, 5'd4);
		send_mem(op_store, w_lw, 32'h84, 32'h0, 5'd4);
		// set the sign bit on some lanes so extension is exercised
		for (off = 0; off < 4; off++) begin
			send_mem(op_store, w_lb, 32'h80 + off, rand32() | (off[0] ? 32'h0 : 32'h80), 5'd5);
		end
		for (off = 0; off < 4; off += 2) begin
			send_mem(op_store, w_lh, 32'h84 + off, rand32() | (off == 2 ? 32'h8000 : 32'h0), 5'd6);
		end
		for (off = 0; off < 4; off++) begin
			send_mem(op_load, w_lb, 32'h80 + off, 32'h0, 5'd7);
			send_mem(op_load, w_lbu, 32'h80 + off, 32'h0, 5'd8);
		end
		for (off = 0; off < 4; off += 2) begin
			send_mem(op_load, w_lh, 32'h84 + off, 32'h0, 5'd9);
			send_mem(op_load, w_lhu, 32'h84 + off, 32'h0, 5'd10);
		end
		send_mem(op_load, w_lw, 32'h80, 32'h0, 5'd11);
		send_mem(op_load, w_lw, 32'h84, 32'h0, 5'd12);
		wait_all_received();
		end_test(4, "byte and half lanes", errs);

		errs = error_count;
		send_mem(op_store, w_lw, 32'h10, 32'h12345678, 5'd13);
		send_mem(op_load, w_lw, 32'h400, 32'h0, 5'd14);
		// 0x410 aliases word 4 in the SRAM index bits
		send_mem(op_store, w_lw, 32'h410, 32'hffffffff, 5'd15);
		send_mem(op_load, w_lw, 32'h10, 32'h0, 5'd16);
		wait_all_received();
		end_test(5, "out-of-range faults", errs);

		errs = error_count;
		bp_on = 1'b1;
		for (int k = 0; k < 16; k++) begin
			send_mem(op_store, w_lw, 32'h100 + 4 * k, rand32(), 5'd1);
		end
		for (int k = 0; k < 60; k++) begin
			kind = rand16() % 3;
			r    = rand16();
			addr = 32'h100 + (rand16() % 16) * 4;
			if (kind == 0) begin
				send_item(op_none, w_lw, addr, rand32(), rand32(), r[4:0], r[5], r[6], r[15:8]);
			end else begin
				op = (kind == 1) ? op_load : op_store;
				case (rand16() % 5)
					0:       w = w_lb;
					1:       w = (op == op_load) ? w_lbu : w_lb;
					2:       w = w_lh;
					3:       w = (op == op_load) ? w_lhu : w_lh;
					default: w = w_lw;
				endcase
				case (w)
					w_lb, w_lbu: off = rand16() % 4;
					w_lh, w_lhu: off = (rand16() % 2) * 2;
					default:     off = 0;
				endcase
				if (rand16() % 8 == 0) begin
					addr = addr + 32'h800;
				end
				send_mem(op, w, addr + off, rand32(), r[4:0]);
			end
		end
		wait_all_received();
		bp_on = 1'b0;
		assert (timed_out || sent_count == received_count)
			else begin
				$display("items lost or repeated: %0d sent, %0d received",
					sent_count, received_count);
				error_count++;
			end
		end_test(6, "random mix with back-pressure", errs);

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+tests
src/axi_lite_pkg.sv
src/mem_op_pkg.sv
src/pipe_slice.sv
src/lane_align.sv
src/mem_access_unit.sv
src/axi_sram.sv
src/mem_stage_top.sv
tests/tb_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory stage testbench with Verilator
# the result is taken from the log, a missing pass line fails the run
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_mem_stage \
	-f sim.f -o tb_mem_stage \
	|| { echo "build failed"; exit 1; }
./obj_dir/tb_mem_stage > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx -- '>>> PASS' sim.log && exit 0 || exit 1
